//--- flist.f
+incdir+common
common/uop_pkg.sv
expander/uop_expander.sv
source/carry_prefix_tracker.sv
source/uop_sequencer.sv
source/uop_front_end.sv
verification/tb_uop_front_end.sv

//--- run_sim.sh
#!/bin/sh
# Builds the front end testbench with Verilator, runs it and checks the log
rm -f sim.log &&
verilator --binary --timing --assert -f flist.f --top-module tb_uop_front_end -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ||
echo "Build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- verification/tb_uop_front_end.sv
// Table-driven testbench for the micro-op front end; compile with flist.f, top tb_uop_front_end
`timescale 1ns/1ps
`include "uop_settings.svh"

module tb_uop_front_end;
	import uop_pkg::*;

	localparam int TABLE_MAX = 32;
	// Cycles any single wait may take
	localparam int WAIT_MAX = 200;

	logic         clk = 1'b0;
	logic         rst_n;
	logic         in_valid;
	logic         in_ready;
	instruction_t in_ir;
	logic         uop_valid;
	micro_op_t    uop_out;
	logic         out_ready;

	// Stimulus table with test number, word and expected micro-op count per row
	int           table_test [TABLE_MAX];
	instruction_t table_ir [TABLE_MAX];
	int           table_cnt [TABLE_MAX];
	int           n_words = 0;

	// Reference model state
	micro_op_t    exp_q [$];
	carry_state_t m_carry = '0;
	int           m_span = 0;
	int           pushed = 0;

	int seq_errors = 0;
	int mon_errors = 0;
	int xfers = 0;
	int tests_pass = 0;
	int tests_fail = 0;
	int cyc = 0;
	int accept_cyc = 0;
	bit hung = 1'b0;
	bit stall_en = 1'b1;
	bit timing_watch = 1'b0;

	uop_front_end DUT (.*);

	always #50 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ==============================
	// Word building and model
	// ==============================

	function automatic instruction_t word(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
		logic rec, logic imm, logic [12:0] r2);
		instruction_t w;
		w = {imm, r2, rec, rs1, rd, op};
		return w;
	endfunction

	// Derived micro-op with record bit clear and bank bits zero
	function automatic micro_op_t uop(logic [3:0] xop, opcode_e op, logic [4:0] rd,
		logic [4:0] rs1, logic imm, logic [12:0] r2);
		micro_op_t u;
		u = '0;
		u.xop = xop;
		u.ins = word(op, rd, rs1, 1'b0, imm, r2);
		return u;
	endfunction

	function automatic micro_op_t pass_op(instruction_t w);
		micro_op_t u;
		u = '0;
		u.ins = w;
		return u;
	endfunction

	// Expands one word by the front end rules, queues the result, returns the count
	function automatic int predict(instruction_t w);
		micro_op_t    g [$];
		carry_state_t c;
		logic [4:0]   cr;
		logic         is_add;
		c = '0;
		if (m_span > 0)
			c = m_carry;
		cr = c.carry_reg[4:0];
		is_add = (w.opcode == OP_ADD || w.opcode == OP_SUBF);
		if (w.opcode == OP_CARRY)
		begin
			// carry_in, carry_out, then a bank-0 register
			m_carry = {w.rs1[0], w.rs1[1], 2'b00, w.rd};
			m_span = int'(w.rs2_imm[1:0]) + 1;
			return 0;
		end
		if (m_span > 0)
			m_span--;
		if (is_add && c.carry_in && c.carry_out)
		begin
			g.push_back(uop(4'd0, w.opcode, `TMP_REG, w.rs1, 1'b0, {8'd0, cr}));
			g.push_back(uop(4'd0, w.opcode, `TMP_REG, `TMP_REG, w.imm_flag, w.rs2_imm));
			g.push_back(uop(4'd0, w.opcode, w.rd, w.rs1, 1'b0, {8'd0, cr}));
			g.push_back(uop(4'd1, w.opcode, cr, w.rd, w.imm_flag, w.rs2_imm));
			g.push_back(uop(4'd0, OP_MOV, w.rd, `TMP_REG, 1'b0, 13'd0));
		end
		else if (is_add && c.carry_in)
		begin
			g.push_back(uop(4'd0, w.opcode, w.rd, w.rs1, 1'b0, {8'd0, cr}));
			g.push_back(uop(4'd0, w.opcode, w.rd, w.rd, w.imm_flag, w.rs2_imm));
		end
		else if (is_add && c.carry_out)
		begin
			// AGC writes the carry register ahead of the untouched original
			g.push_back(uop(4'd1, w.opcode, cr, w.rs1, w.imm_flag, w.rs2_imm));
			g.push_back(pass_op(w));
		end
		else if (w.opcode == OP_BCC && w.rd[2:0] != NO_DEC_A && w.rd[2:0] != NO_DEC_B)
		begin
			g.push_back(uop(4'd0, OP_ADD, `LC_REG, `LC_REG, 1'b1, 13'h1FFF));
			g.push_back(pass_op(w));
		end
		else
			g.push_back(pass_op(w));
		// Compare kind sits in rs2_imm bits 6:5 and the CR number in rd
		if (w.rec && (is_add || w.opcode inside {OP_AND, OP_OR, OP_SHIFT, OP_MOV, OP_LOAD}))
			g.push_back(uop(4'd0, OP_CMP, 5'd0, w.rd, 1'b0, 13'd0));
		else if (w.rec && w.opcode == OP_FLT)
			g.push_back(uop(4'd0, OP_CMP, 5'd1, w.rd, 1'b0, {6'd0, 2'd2, 5'd0}));
		g[0].num = 3'(g.size());
		foreach (g[i])
			exp_q.push_back(g[i]);
		pushed += g.size();
		return g.size();
	endfunction

	// ==============================
	// Stimulus table
	// ==============================

	task automatic add_entry(input int t, input instruction_t w, input int cnt);
		table_test[n_words] = t;
		table_ir[n_words] = w;
		table_cnt[n_words] = cnt;
		n_words++;
	endtask

	task automatic load_table();
		// Plain and record-bit words
		add_entry(2, word(OP_AND, 5'd3, 5'd1, 1'b0, 1'b0, 13'd2), 1);
		add_entry(2, word(OP_AND, 5'd3, 5'd1, 1'b1, 1'b0, 13'd2), 2);
		add_entry(2, word(OP_OR, 5'd6, 5'd4, 1'b1, 1'b1, 13'h0A5), 2);
		add_entry(2, word(OP_FLT, 5'd9, 5'd8, 1'b1, 1'b0, 13'd7), 2);
		add_entry(2, word(OP_STORE, 5'd2, 5'd3, 1'b1, 1'b1, 13'd16), 1);
		add_entry(2, word(OP_ADD, 5'd11, 5'd1, 1'b1, 1'b0, 13'd2), 2);
		// Carry-in, span 1, then expired
		add_entry(3, word(OP_CARRY, 5'd7, 5'b00001, 1'b0, 1'b0, 13'd0), 0);
		add_entry(3, word(OP_ADD, 5'd4, 5'd5, 1'b0, 1'b0, 13'd6), 2);
		add_entry(3, word(OP_ADD, 5'd4, 5'd5, 1'b0, 1'b0, 13'd6), 1);
		// Carry-out with record bit
		add_entry(3, word(OP_CARRY, 5'd8, 5'b00010, 1'b0, 1'b0, 13'd0), 0);
		add_entry(3, word(OP_SUBF, 5'd9, 5'd10, 1'b1, 1'b1, 13'h123), 3);
		// Both flags over a span of 2
		add_entry(3, word(OP_CARRY, 5'd7, 5'b00011, 1'b0, 1'b0, 13'd1), 0);
		add_entry(3, word(OP_ADD, 5'd1, 5'd2, 1'b0, 1'b0, 13'd3), 5);
		add_entry(3, word(OP_ADD, 5'd1, 5'd2, 1'b1, 1'b1, 13'h1F0), 6);
		add_entry(3, word(OP_ADD, 5'd1, 5'd2, 1'b0, 1'b0, 13'd3), 1);
		// Branches
		add_entry(4, word(OP_BCC, 5'd2, 5'd0, 1'b0, 1'b1, 13'h040), 1);
		add_entry(4, word(OP_BCC, 5'd5, 5'd0, 1'b0, 1'b1, 13'h080), 1);
		add_entry(4, word(OP_BCC, 5'd0, 5'd0, 1'b0, 1'b1, 13'h0C0), 2);
		add_entry(4, word(OP_BCC, 5'd3, 5'd0, 1'b1, 1'b1, 13'h100), 2);
		// Back-to-back timing with no stalls
		add_entry(6, word(OP_AND, 5'd3, 5'd1, 1'b1, 1'b0, 13'd2), 2);
		add_entry(6, word(OP_BCC, 5'd1, 5'd0, 1'b0, 1'b1, 13'h010), 2);
		add_entry(6, word(OP_OR, 5'd5, 5'd6, 1'b0, 1'b0, 13'd7), 1);
		add_entry(6, word(OP_FLT, 5'd2, 5'd3, 1'b1, 1'b0, 13'd4), 2);
		add_entry(6, word(OP_MOV, 5'd8, 5'd9, 1'b0, 1'b0, 13'd0), 1);
	endtask

	// ==============================
	// Drivers and monitor
	// ==============================

	// Output back-pressure drops out_ready about one cycle in four
	initial
	begin
		void'($urandom(32'h8285_f8ae));
		out_ready = 1'b1;
		forever
		begin
			@(posedge clk);
			#1;
			out_ready = !stall_en || ($urandom % 4 != 0);
		end
	end

	// Inputs settle 1 ns after the edge, so a transfer is known at the falling edge
	always @(negedge clk)
	begin
		micro_op_t exp_op;
		if (timing_watch && exp_q.size() != 0)
			assert (uop_valid)
			else
			begin
				$display("[FAIL] %0t idle output cycle between groups", $time);
				mon_errors++;
			end
		if (rst_n && uop_valid && out_ready)
		begin
			xfers++;
			if (exp_q.size() == 0)
			begin
				$display("Micro-op issued at %0t with nothing left to expect", $time);
				mon_errors++;
			end
			else
			begin
				exp_op = exp_q.pop_front();
				assert (uop_out === exp_op)
				else
				begin
					$display("[FAIL] %0t micro-op %h, expected %h", $time, uop_out, exp_op);
					mon_errors++;
				end
				// First micro-op leaves the cycle after its word was taken
				if (timing_watch && exp_op.num != '0)
					assert (cyc == accept_cyc)
					else
					begin
						$display("[FAIL] %0t first micro-op %0d cycles late", $time,
							cyc - accept_cyc);
						mon_errors++;
					end
			end
		end
	end

	function automatic int err_total();
		return seq_errors + mon_errors;
	endfunction

	// Presents one word 1 ns after an edge and holds it until accepted
	task automatic apply(input instruction_t w, input int cnt);
		int waited;
		int got;
		got = predict(w);
		assert (got == cnt)
		else
		begin
			$display("[FAIL] %0t model gives %0d micro-ops, table %0d", $time, got, cnt);
			seq_errors++;
		end
		in_valid = 1'b1;
		in_ir = w;
		waited = 0;
		@(negedge clk);
		while (!in_ready && waited < WAIT_MAX)
		begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready)
		begin
			$display("Timed out at %0t waiting for in_ready", $time);
			seq_errors++;
			hung = 1'b1;
		end
		@(posedge clk);
		#1;
		accept_cyc = cyc;
		in_valid = 1'b0;
	endtask

	// Waits until every expected micro-op has gone out
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_MAX)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Timed out with %0d expected micro-ops never issued", exp_q.size());
			seq_errors++;
			hung = 1'b1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic report_test(input int t, input string name, input int mark);
		if (err_total() == mark)
		begin
			tests_pass++;
			$display("Test %0d, %s: ok", t, name);
		end
		else
		begin
			tests_fail++;
			$display("Test %0d, %s: %0d errors", t, name, err_total() - mark);
		end
	endtask

	task automatic run_checked(input int t, input string name);
		int mark;
		mark = err_total();
		for (int i = 0; i < n_words; i++)
		begin
			if (table_test[i] == t && !hung)
			begin
				apply(table_ir[i], table_cnt[i]);
				// Latency and gap checks start once the first group is in
				timing_watch = (t == 6);
			end
		end
		if (!hung)
			drain();
		timing_watch = 1'b0;
		report_test(t, name, mark);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		int mark;
		int mark_all;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_ir = '0;
		load_table();
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		mark = err_total();
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			assert (!uop_valid && in_ready)
			else
			begin
				$display("[FAIL] %0t idle uop_valid %b in_ready %b", $time, uop_valid, in_ready);
				seq_errors++;
			end
		end
		report_test(1, "idle after reset", mark);
		@(posedge clk);
		#1;
		mark_all = err_total();
		run_checked(2, "plain and record-bit words");
		if (!hung)
			run_checked(3, "carry prefixes and expiry");
		if (!hung)
			run_checked(4, "branch loop-counter decrement");
		if (!hung)
		begin
			if (xfers != pushed)
			begin
				$display("Issued %0d micro-ops where %0d were expected", xfers, pushed);
				seq_errors++;
			end
			report_test(5, "every micro-op once and in order under stalls", mark_all);
			// Stalls turn off at a falling edge away from the drive edge
			@(negedge clk);
			stall_en = 1'b0;
			@(posedge clk);
			#1;
			run_checked(6, "issue latency and back-to-back groups");
		end
		$display("Tests: %0d ok, %0d with errors", tests_pass, tests_fail);
		if (tests_fail == 0 && !hung && err_total() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- source/uop_front_end.sv
// Top of the micro-op front end, chaining prefix tracker, expander and sequencer
`timescale 1ns/1ps
`include "uop_settings.svh"

module uop_front_end (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  uop_pkg::instruction_t in_ir,
	output logic                  uop_valid,
	output uop_pkg::micro_op_t    uop_out,
	input  logic                  out_ready
);
	import uop_pkg::*;

	// Tracker to expander and sequencer
	logic                           fwd_valid;
	carry_state_t                   cur_carry;
	// Expander to sequencer
	micro_op_t [`UOP_GROUP_MAX-1:0] grp;
	logic [`UOP_COUNT_W-1:0]        grp_count;

	// ==============================
	// Pipeline
	// ==============================

	carry_prefix_tracker u_tracker (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_ir     (in_ir),
		.fwd_valid (fwd_valid),
		.cur_carry (cur_carry)
	);

	uop_expander u_expander (
		.ir        (in_ir),
		.carry     (cur_carry),
		.grp       (grp),
		.grp_count (grp_count)
	);

	uop_sequencer u_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.fwd_valid (fwd_valid),
		.grp       (grp),
		.grp_count (grp_count),
		.in_ready  (in_ready),
		.uop_valid (uop_valid),
		.uop_out   (uop_out),
		.out_ready (out_ready)
	);

endmodule

//--- source/uop_sequencer.sv
// Holds one expanded micro-op group and issues it one micro-op per transfer under back-pressure
`timescale 1ns/1ps
`include "uop_settings.svh"

module uop_sequencer (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    fwd_valid,
	input  uop_pkg::micro_op_t [`UOP_GROUP_MAX-1:0] grp,
	input  logic [`UOP_COUNT_W-1:0]                 grp_count,
	output logic                                    in_ready,
	output logic                                    uop_valid,
	output uop_pkg::micro_op_t                      uop_out,
	input  logic                                    out_ready
);
	import uop_pkg::*;

	// Captured group, payload only
	micro_op_t [`UOP_GROUP_MAX-1:0] grp_q;
	// Slot currently on the output
	logic [`UOP_COUNT_W-1:0]        idx_q;
	// Micro-ops still to go, zero when empty
	logic [`UOP_COUNT_W-1:0]        left_q;
	logic                           xfer;
	logic                           last_xfer;
	logic                           load;

	// ==============================
	// Handshakes
	// ==============================

	assign uop_valid = (left_q != '0);
	assign uop_out = grp_q[idx_q];
	assign xfer = uop_valid && out_ready;
	// Final micro-op of the group leaves this cycle
	assign last_xfer = xfer && (left_q == `UOP_COUNT_W'(1));
	// Empty, or emptying now, so back-to-back groups have no gap
	assign in_ready = !uop_valid || last_xfer;
	assign load = fwd_valid && in_ready;

	// ==============================
	// Issue state
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			idx_q <= '0;
			left_q <= '0;
		end
		else if (load)
		begin
			// New group starts at slot 0
			idx_q <= '0;
			left_q <= grp_count;
		end
		else if (xfer)
		begin
			idx_q <= idx_q + `UOP_COUNT_W'(1);
			left_q <= left_q - `UOP_COUNT_W'(1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			grp_q <= grp;
	end

	// Stalled output must not change
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid && !out_ready |=> uop_valid && $stable(uop_out));

endmodule

//--- source/carry_prefix_tracker.sv
// Consumes carry-prefix words and supplies carry state to the instructions the prefix covers
`timescale 1ns/1ps
`include "uop_settings.svh"

module carry_prefix_tracker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  in_ready,
	input  uop_pkg::instruction_t in_ir,
	output logic                  fwd_valid,
	output uop_pkg::carry_state_t cur_carry
);
	import uop_pkg::*;

	// Span counts 0 up to the prefix limit
	localparam int SPAN_W = $clog2(`CARRY_SPAN_MAX + 1);

	carry_state_t      carry_q;
	logic [SPAN_W-1:0] span_q;
	logic              is_prefix;
	logic              accept;

	// Only place a prefix is recognized
	assign is_prefix = (in_ir.opcode == OP_CARRY);
	assign accept = in_valid && in_ready;

	// Prefix words stop here
	assign fwd_valid = in_valid && !is_prefix;
	// Stale state is hidden once the span runs out
	assign cur_carry = (span_q != '0) ? carry_q : '0;

	// ==============================
	// Prefix state
	// ==============================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			carry_q <= '0;
			span_q <= '0;
		end
		else if (accept)
		begin
			if (is_prefix)
			begin
				// rs1 bit 0 is carry-in, bit 1 carry-out
				carry_q.carry_in <= in_ir.rs1[0];
				carry_q.carry_out <= in_ir.rs1[1];
				// Prefix names a bank-0 register
				carry_q.carry_reg <= {2'b00, in_ir.rd};
				// Covers 1 to 4 following instructions
				span_q <= SPAN_W'(in_ir.rs2_imm[1:0]) + SPAN_W'(1);
			end
			else if (span_q != '0)
				span_q <= span_q - SPAN_W'(1);
		end
	end

	a_span_limit: assert property (@(posedge clk) disable iff (!rst_n)
		span_q <= SPAN_W'(`CARRY_SPAN_MAX));

endmodule

//--- expander/uop_expander.sv
// Combinational expansion of one instruction and its carry state into a micro-op group and count
`timescale 1ns/1ps
`include "uop_settings.svh"

module uop_expander (
	input  uop_pkg::instruction_t                      ir,
	input  uop_pkg::carry_state_t                      carry,
	output uop_pkg::micro_op_t [`UOP_GROUP_MAX-1:0]    grp,
	output logic [`UOP_COUNT_W-1:0]                    grp_count
);
	import uop_pkg::*;

	// Extended op codes
	localparam logic [3:0] XOP_AGC = 4'd1;
	// Compare kinds, carried in rs2_imm bits 6:5 of a compare
	localparam logic [1:0] CMP_INT = 2'd0;
	localparam logic [1:0] CMP_FLT = 2'd2;

	// Builds a derived instruction, record bit always clear
	function automatic instruction_t mk_ins(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
		logic imm_flag, logic [12:0] rs2_imm);
		instruction_t r;
		r.imm_flag = imm_flag;
		r.rs2_imm = rs2_imm;
		r.rec = 1'b0;
		r.rs1 = rs1;
		r.rd = rd;
		r.opcode = op;
		return r;
	endfunction

	// Compare of ir.rd against register 0
	// CR field number goes in rd, register 0 in rs2_imm bits 4:0
	function automatic instruction_t mk_cmp(logic [4:0] src, logic [1:0] kind, logic [2:0] cr);
		return mk_ins(OP_CMP, {2'b00, cr}, src, 1'b0, {6'd0, kind, 5'd0});
	endfunction

	// ==============================
	// Expansion
	// ==============================

	always_comb
	begin
		// Unused slots stay zero
		grp = '0;
		// Default is a plain pass-through
		grp_count = `UOP_COUNT_W'(1);
		grp[0].ins = ir;
		case (ir.opcode)
		OP_AND, OP_OR, OP_SHIFT, OP_MOV, OP_LOAD:
			if (ir.rec)
			begin
				// Integer compare into CR0
				grp[1].ins = mk_cmp(ir.rd, CMP_INT, 3'd0);
				grp_count = `UOP_COUNT_W'(2);
			end
		OP_FLT:
			if (ir.rec)
			begin
				// Float compare into CR1
				grp[1].ins = mk_cmp(ir.rd, CMP_FLT, 3'd1);
				grp_count = `UOP_COUNT_W'(2);
			end
		OP_ADD, OP_SUBF:
		begin
			case ({carry.carry_out, carry.carry_in})
			2'b01:
			begin
				// op rd, rs1, carry_reg
				grp[0].xrs = carry.carry_reg[6:5];
				grp[0].ins = mk_ins(ir.opcode, ir.rd, ir.rs1, 1'b0,
					{8'd0, carry.carry_reg[4:0]});
				// op rd, rd, rs2 or imm
				grp[1].ins = mk_ins(ir.opcode, ir.rd, ir.rd, ir.imm_flag, ir.rs2_imm);
				grp_count = `UOP_COUNT_W'(2);
			end
			2'b10:
			begin
				// AGC into the carry register first
				grp[0].xrd = carry.carry_reg[6:5];
				grp[0].xop = XOP_AGC;
				grp[0].ins.rd = carry.carry_reg[4:0];
				grp[0].ins.rec = 1'b0;
				// Then the original instruction
				grp[1].ins = ir;
				grp_count = `UOP_COUNT_W'(2);
			end
			2'b11:
			begin
				// Sum with carry-in built in TMP
				grp[0].xrs = carry.carry_reg[6:5];
				grp[0].ins = mk_ins(ir.opcode, `TMP_REG, ir.rs1, 1'b0,
					{8'd0, carry.carry_reg[4:0]});
				grp[1].ins = mk_ins(ir.opcode, `TMP_REG, `TMP_REG, ir.imm_flag, ir.rs2_imm);
				// Partial sum in rd feeds the carry generate
				grp[2].xrs = carry.carry_reg[6:5];
				grp[2].ins = mk_ins(ir.opcode, ir.rd, ir.rs1, 1'b0,
					{8'd0, carry.carry_reg[4:0]});
				// AGC carry_reg, rd, rs2 or imm
				grp[3].xrd = carry.carry_reg[6:5];
				grp[3].xop = XOP_AGC;
				grp[3].ins = mk_ins(ir.opcode, carry.carry_reg[4:0], ir.rd, ir.imm_flag,
					ir.rs2_imm);
				// Final sum back into rd
				grp[4].ins = mk_ins(OP_MOV, ir.rd, `TMP_REG, 1'b0, 13'd0);
				grp_count = `UOP_COUNT_W'(5);
			end
			default:
			begin
				// No carry flags, pass-through stands
			end
			endcase
			// Record bit closes any add sequence with a CR0 compare
			if (ir.rec)
			begin
				grp[grp_count].ins = mk_cmp(ir.rd, CMP_INT, 3'd0);
				grp_count = grp_count + `UOP_COUNT_W'(1);
			end
		end
		OP_BCC:
			if (ir.rd[2:0] != NO_DEC_A && ir.rd[2:0] != NO_DEC_B)
			begin
				// ADD LC, LC, -1 ahead of the branch
				grp[0].ins = mk_ins(OP_ADD, `LC_REG, `LC_REG, 1'b1, 13'h1FFF);
				grp[1].ins = ir;
				grp_count = `UOP_COUNT_W'(2);
			end
		default:
		begin
			// Everything else passes through
		end
		endcase
		// Count rides in slot 0 only
		grp[0].num = grp_count;
		// Longest path is the five-op carry chain plus its compare
		assert (grp_count >= `UOP_COUNT_W'(1) && grp_count <= `UOP_COUNT_W'(6))
		else $error("expander count %0d out of range", grp_count);
	end

endmodule

//--- common/uop_pkg.sv
// Shared types of the micro-op front end; modules import it inside their bodies
`include "uop_settings.svh"

package uop_pkg;

	// ==============================
	// Opcodes
	// ==============================

	// Small subset, one or two per class
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_BRK   = 7'h01,
		OP_ADD   = 7'h04,
		OP_SUBF  = 7'h05,
		OP_AND   = 7'h08,
		OP_OR    = 7'h09,
		OP_SHIFT = 7'h0C,
		OP_CMP   = 7'h0D,
		OP_MOV   = 7'h0E,
		OP_LOAD  = 7'h40,
		OP_STORE = 7'h48,
		OP_FLT   = 7'h50,
		OP_BCC   = 7'h60,
		// Carry prefix, consumed by the tracker
		OP_CARRY = 7'h7E
	} opcode_e;

	// ==============================
	// Instruction word
	// ==============================

	// Fields listed from bit 31 down to bit 0
	typedef struct packed {
		// Selects the 13-bit immediate over rs2
		logic        imm_flag;
		// rs2 in bits 4:0, or the whole immediate
		logic [12:0] rs2_imm;
		// Record bit, asks for a compare to zero
		logic        rec;
		logic [4:0]  rs1;
		// Destination, or branch condition in bits 2:0
		logic [4:0]  rd;
		opcode_e     opcode;
	} instruction_t;

	// ==============================
	// Micro-op
	// ==============================

	typedef struct packed {
		// Group count in slot 0, zero elsewhere
		logic [`UOP_COUNT_W-1:0] num;
		// Bank extension of rd
		logic [1:0]              xrd;
		// Bank extension of the second source
		logic [1:0]              xrs;
		// Extended op, 0 normal and 1 AGC
		logic [3:0]              xop;
		instruction_t            ins;
	} micro_op_t;

	// Carry chaining state handed from the prefix tracker
	typedef struct packed {
		logic       carry_in;
		logic       carry_out;
		// Bank in bits 6:5, register in bits 4:0
		logic [6:0] carry_reg;
	} carry_state_t;

	// Branch conditions that skip the loop-counter decrement
	localparam logic [2:0] NO_DEC_A = 3'd2;
	localparam logic [2:0] NO_DEC_B = 3'd5;

endpackage

//--- common/uop_settings.svh
// Sizes and fixed register numbers for the micro-op front end; include wherever they are needed
`ifndef UOP_SETTINGS_SVH
`define UOP_SETTINGS_SVH

// ==============================
// Group sizing
// ==============================

// Micro-op slots in one expanded group
`define UOP_GROUP_MAX 8
// Width of a group count
`define UOP_COUNT_W 3

// ==============================
// Fixed registers and limits
// ==============================

// Loop counter, decremented ahead of counted branches
`define LC_REG 5'd12
// Scratch register for carry-in-plus-out chains
`define TMP_REG 5'd15
// Most instructions one carry prefix can cover
`define CARRY_SPAN_MAX 4

`endif
